// ==== list.f ====
logic/cnn_pkg.sv
logic/ddr_reader.sv
logic/tile_buffer.sv
logic/conv_engine.sv
logic/cnn_tile_top.sv
tests/conv_sva.sv
tests/cnn_tile_tb.sv

// ==== logic/cnn_pkg.sv ====
/* widths, tile geometry and state encodings shared by the tile-convolution core
   DATA_W and TILE are defaults only, the top level passes its own values to the modules */
package cnn_pkg;

    // signed feature and weight element
    localparam int DATA_W   = 16;

    // square input tile and kernel edges
    localparam int TILE     = 6;
    localparam int KS       = 3;

    // valid convolution positions along one tile edge
    localparam int OUT_EDGE = TILE - KS + 1;

    // one DDR beat carries one full tile row
    localparam int ROW_W    = TILE * DATA_W;

    // full product width plus growth for nine terms
    localparam int ACC_W    = 2 * DATA_W + 4;

    // DDR row address
    localparam int ADDR_W   = 30;

    // DDR reader FSM
    typedef enum logic [1:0]
    {
        RD_IDLE,
        RD_REQ,
        RD_DRAIN,
        RD_WAIT_BANK
    } rd_state_e;

    // convolution engine FSM
    typedef enum logic
    {
        CV_IDLE,
        CV_RUN
    } conv_state_e;

endpackage

// ==== logic/cnn_tile_top.sv ====
/* tile convolution core, DDR row reads feed a ping-pong tile buffer that feeds the 3x3 engine
   load the nine kernel weights before start_i, the last out_last_o of a run marks its end */
`timescale 1ns/10ps
module cnn_tile_top
    import cnn_pkg::*;
#(
    parameter int DATA_W    = cnn_pkg::DATA_W,
    parameter int TILE      = cnn_pkg::TILE,
    localparam int ROW_W    = TILE * DATA_W,
    localparam int ACC_W    = 2 * DATA_W + 4,
    localparam int POS_W    = $clog2(TILE - KS + 1)
)
(
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        start_i,
    input  logic [ADDR_W-1:0]           base_addr_i,
    input  logic [7:0]                  tile_count_i,
    input  logic                        wt_valid_i,
    input  logic signed [DATA_W-1:0]    wt_data_i,
    input  logic                        ddr_rdy_i,
    input  logic                        ddr_rd_data_valid_i,
    input  logic [ROW_W-1:0]            ddr_rd_data_i,
    output logic                        ddr_en_o,
    output logic [ADDR_W-1:0]           ddr_addr_o,
    output logic                        out_valid_o,
    output logic [ACC_W-1:0]            out_data_o,
    output logic [POS_W-1:0]            out_x_o,
    output logic [POS_W-1:0]            out_y_o,
    output logic                        out_last_o,
    output logic [1:0]                  reg_matrix_full_o
);

    // reader to buffer
    logic                   row_wr;
    logic [ROW_W-1:0]       row_data;
    logic                   wr_free;

    // buffer to engine
    logic                   bank_ready;
    logic [TILE*ROW_W-1:0]  tile_data;
    logic                   bank_release;

    ddr_reader #(
        .DATA_W ( DATA_W ),
        .TILE   ( TILE   )
    ) reader_U (
        .clk_i               ( clk_i               ),
        .rstn_i              ( rstn_i              ),
        .start_i             ( start_i             ),
        .base_addr_i         ( base_addr_i         ),
        .tile_count_i        ( tile_count_i        ),
        .ddr_rdy_i           ( ddr_rdy_i           ),
        .ddr_rd_data_valid_i ( ddr_rd_data_valid_i ),
        .ddr_rd_data_i       ( ddr_rd_data_i       ),
        .wr_free_i           ( wr_free             ),
        .ddr_en_o            ( ddr_en_o            ),
        .ddr_addr_o          ( ddr_addr_o          ),
        .row_wr_o            ( row_wr              ),
        .row_data_o          ( row_data            )
    );

    tile_buffer #(
        .DATA_W ( DATA_W ),
        .TILE   ( TILE   )
    ) buffer_U (
        .clk_i          ( clk_i             ),
        .rstn_i         ( rstn_i            ),
        .row_wr_i       ( row_wr            ),
        .row_data_i     ( row_data          ),
        .bank_release_i ( bank_release      ),
        .wr_free_o      ( wr_free           ),
        .bank_ready_o   ( bank_ready        ),
        .tile_data_o    ( tile_data         ),
        .full_o         ( reg_matrix_full_o )
    );

    conv_engine #(
        .DATA_W ( DATA_W ),
        .TILE   ( TILE   )
    ) engine_U (
        .clk_i          ( clk_i        ),
        .rstn_i         ( rstn_i       ),
        .wt_valid_i     ( wt_valid_i   ),
        .wt_data_i      ( wt_data_i    ),
        .bank_ready_i   ( bank_ready   ),
        .tile_data_i    ( tile_data    ),
        .bank_release_o ( bank_release ),
        .out_valid_o    ( out_valid_o  ),
        .out_data_o     ( out_data_o   ),
        .out_x_o        ( out_x_o      ),
        .out_y_o        ( out_y_o      ),
        .out_last_o     ( out_last_o   )
    );

endmodule

// ==== logic/conv_engine.sv ====
/* 3x3 signed convolution with ReLU over one tile, one output pixel per cycle in raster order
   the kernel is shifted in row-major and must be complete before the first tile arrives */
`timescale 1ns/10ps
module conv_engine
    import cnn_pkg::*;
#(
    parameter int DATA_W   = cnn_pkg::DATA_W,
    parameter int TILE     = cnn_pkg::TILE,
    localparam int ROW_W   = TILE * DATA_W,
    localparam int ACC_W   = 2 * DATA_W + 4,
    localparam int OUT_EDGE = TILE - KS + 1,
    localparam int POS_W   = $clog2(OUT_EDGE)
)
(
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        wt_valid_i,
    input  logic signed [DATA_W-1:0]    wt_data_i,
    input  logic                        bank_ready_i,
    input  logic [TILE*ROW_W-1:0]       tile_data_i,
    output logic                        bank_release_o,
    output logic                        out_valid_o,
    output logic [ACC_W-1:0]            out_data_o,
    output logic [POS_W-1:0]            out_x_o,
    output logic [POS_W-1:0]            out_y_o,
    output logic                        out_last_o
);

    conv_state_e                state_q;
    logic signed [DATA_W-1:0]   w_q [KS*KS];
    logic [POS_W-1:0]           x_q;
    logic [POS_W-1:0]           y_q;
    logic                       pos_last;
    logic signed [DATA_W-1:0]   pix;
    logic signed [2*DATA_W-1:0] prod;
    logic signed [ACC_W-1:0]    acc;
    int                         idx;

    // kernel shift register, first beat ends up in w_q[0]
    always_ff @(posedge clk_i)
    begin
        if (wt_valid_i)
        begin
            for (int k = 0; k < KS*KS - 1; k++)
                w_q[k] <= w_q[k+1];
            w_q[KS*KS-1] <= wt_data_i;
        end
    end

    // sum of products at the current window
    always_comb
    begin
        acc  = '0;
        pix  = '0;
        prod = '0;
        idx  = 0;
        for (int i = 0; i < KS; i++)
        begin
            for (int j = 0; j < KS; j++)
            begin
                idx  = ((int'(y_q) + i) * TILE + int'(x_q) + j) * DATA_W;
                pix  = tile_data_i[idx +: DATA_W];
                prod = pix * w_q[i*KS + j];
                acc  = acc + ACC_W'(prod);
            end
        end
    end

    assign pos_last = (x_q == POS_W'(OUT_EDGE - 1)) && (y_q == POS_W'(OUT_EDGE - 1));

    // the bank is handed back together with the last pixel
    assign bank_release_o = out_last_o;

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            state_q     <= CV_IDLE;
            x_q         <= '0;
            y_q         <= '0;
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
        end
        else
        begin
            out_valid_o <= (state_q == CV_RUN);
            out_last_o  <= (state_q == CV_RUN) && pos_last;
            case (state_q)
                CV_IDLE:
                begin
                    // bank_ready_i is still high in the release cycle
                    if (bank_ready_i && !out_last_o)
                    begin
                        x_q     <= '0;
                        y_q     <= '0;
                        state_q <= CV_RUN;
                    end
                end
                CV_RUN:
                begin
                    if (x_q == POS_W'(OUT_EDGE - 1))
                    begin
                        x_q <= '0;
                        y_q <= y_q + 1'b1;
                    end
                    else
                    begin
                        x_q <= x_q + 1'b1;
                    end
                    if (pos_last)
                        state_q <= CV_IDLE;
                end
                default: state_q <= CV_IDLE;
            endcase
        end
    end

    // ReLU on the registered pixel
    always_ff @(posedge clk_i)
    begin
        out_data_o <= acc[ACC_W-1] ? '0 : acc;
        out_x_o    <= x_q;
        out_y_o    <= y_q;
    end

endmodule

// ==== logic/ddr_reader.sv ====
/* reads tile_count_i tiles of TILE rows each from consecutive DDR row addresses
   returns must come back in command order, and the next tile waits for a free bank */
`timescale 1ns/10ps
module ddr_reader
    import cnn_pkg::*;
#(
    parameter int DATA_W   = cnn_pkg::DATA_W,
    parameter int TILE     = cnn_pkg::TILE,
    localparam int ROW_W   = TILE * DATA_W
)
(
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                start_i,
    input  logic [ADDR_W-1:0]   base_addr_i,
    input  logic [7:0]          tile_count_i,
    input  logic                ddr_rdy_i,
    input  logic                ddr_rd_data_valid_i,
    input  logic [ROW_W-1:0]    ddr_rd_data_i,
    input  logic                wr_free_i,
    output logic                ddr_en_o,
    output logic [ADDR_W-1:0]   ddr_addr_o,
    output logic                row_wr_o,
    output logic [ROW_W-1:0]    row_data_o
);

    localparam int CNT_W = $clog2(TILE + 1);

    rd_state_e          state_q;
    logic [CNT_W-1:0]   cmd_cnt_q;
    logic [CNT_W-1:0]   ret_cnt_q;
    logic [7:0]         tiles_left_q;
    logic [ADDR_W-1:0]  addr_q;
    logic               beat_valid_q;
    logic [ROW_W-1:0]   beat_q;
    logic               cmd_fire;
    logic               cmd_last;
    logic               ret_last;

    // a command is accepted when enable and ready meet
    assign cmd_fire = ddr_en_o && ddr_rdy_i;
    assign cmd_last = cmd_fire && (cmd_cnt_q == CNT_W'(TILE - 1));
    assign ret_last = beat_valid_q && (ret_cnt_q == CNT_W'(TILE - 1));

    assign ddr_en_o   = (state_q == RD_REQ);
    assign ddr_addr_o = addr_q;
    assign row_wr_o   = beat_valid_q;
    assign row_data_o = beat_q;

    // returned beats get one register stage before the buffer write
    always_ff @(posedge clk_i)
    begin
        beat_q <= ddr_rd_data_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            state_q      <= RD_IDLE;
            cmd_cnt_q    <= '0;
            ret_cnt_q    <= '0;
            tiles_left_q <= '0;
            addr_q       <= '0;
            beat_valid_q <= 1'b0;
        end
        else
        begin
            beat_valid_q <= ddr_rd_data_valid_i;
            if (beat_valid_q)
                ret_cnt_q <= ret_last ? '0 : ret_cnt_q + 1'b1;
            // address holds while ddr_rdy_i is low
            if (cmd_fire)
            begin
                addr_q    <= addr_q + 1'b1;
                cmd_cnt_q <= cmd_last ? '0 : cmd_cnt_q + 1'b1;
            end
            case (state_q)
                RD_IDLE:
                begin
                    if (start_i && (tile_count_i != 8'd0))
                    begin
                        addr_q       <= base_addr_i;
                        tiles_left_q <= tile_count_i;
                        state_q      <= wr_free_i ? RD_REQ : RD_WAIT_BANK;
                    end
                end
                RD_REQ:
                begin
                    if (cmd_last)
                        state_q <= RD_DRAIN;
                end
                RD_DRAIN:
                begin
                    // tile complete once its last row is written
                    if (ret_last)
                    begin
                        tiles_left_q <= tiles_left_q - 1'b1;
                        state_q      <= (tiles_left_q == 8'd1) ? RD_IDLE : RD_WAIT_BANK;
                    end
                end
                RD_WAIT_BANK:
                begin
                    if (wr_free_i)
                        state_q <= RD_REQ;
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/tile_buffer.sv ====
/* two-bank ping-pong tile store, element (r,c) of the read tile sits at bit (r*TILE+c)*DATA_W
   the writer must only write while wr_free_o is high, nothing here guards a full bank */
`timescale 1ns/10ps
module tile_buffer
    import cnn_pkg::*;
#(
    parameter int DATA_W   = cnn_pkg::DATA_W,
    parameter int TILE     = cnn_pkg::TILE,
    localparam int ROW_W   = TILE * DATA_W
)
(
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    row_wr_i,
    input  logic [ROW_W-1:0]        row_data_i,
    input  logic                    bank_release_i,
    output logic                    wr_free_o,
    output logic                    bank_ready_o,
    output logic [TILE*ROW_W-1:0]   tile_data_o,
    output logic [1:0]              full_o
);

    localparam int ROW_CNT_W = $clog2(TILE);

    logic [ROW_W-1:0]       mem_q [2][TILE];
    logic [ROW_CNT_W-1:0]   wr_row_q;
    logic                   wr_sel_q;
    logic                   rd_sel_q;
    logic [1:0]             full_q;
    logic [1:0]             full_next;
    logic                   row_last;

    assign row_last = row_wr_i && (wr_row_q == ROW_CNT_W'(TILE - 1));

    // row storage
    always_ff @(posedge clk_i)
    begin
        if (row_wr_i)
            mem_q[wr_sel_q][wr_row_q] <= row_data_i;
    end

    // release and fill can hit the two banks in the same cycle
    always_comb
    begin
        full_next = full_q;
        if (bank_release_i)
            full_next[rd_sel_q] = 1'b0;
        if (row_last)
            full_next[wr_sel_q] = 1'b1;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            wr_row_q <= '0;
            wr_sel_q <= 1'b0;
            rd_sel_q <= 1'b0;
            full_q   <= 2'b00;
        end
        else
        begin
            full_q <= full_next;
            if (row_wr_i)
            begin
                if (row_last)
                begin
                    wr_row_q <= '0;
                    wr_sel_q <= ~wr_sel_q;
                end
                else
                begin
                    wr_row_q <= wr_row_q + 1'b1;
                end
            end
            if (bank_release_i)
                rd_sel_q <= ~rd_sel_q;
        end
    end

    // read bank flattened row by row
    for (genvar r = 0; r < TILE; r++)
    begin : g_rows
        assign tile_data_o[r*ROW_W +: ROW_W] = mem_q[rd_sel_q][r];
    end

    assign wr_free_o    = ~full_q[wr_sel_q];
    assign bank_ready_o = full_q[rd_sel_q];
    assign full_o       = full_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f --top-module cnn_tile_tb -o sim \
    > build.log 2>&1
then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
    exit 0
fi
exit 1

// ==== tests/cnn_tile_tb.sv ====
/* cases come from tests/tile_cases.txt and run from the project root, case c reads rows from
   ADDR_HIGH + c*32 on, the DDR model answers in order after 1 to 6 cycles by low 8 address bits */
`timescale 1ns/10ps
module cnn_tile_tb
    import cnn_pkg::*;
();

    localparam int T_EDGE    = 6;
    localparam int K_EDGE    = 3;
    localparam int O_EDGE    = 4;
    localparam int BASE_STEP = 32;
    localparam logic [ADDR_W-1:0] ADDR_HIGH = ADDR_W'(32'h1550_0000);

    logic                       clk = 1'b0;
    logic                       rstn = 1'b0;
    logic                       start = 1'b0;
    logic [ADDR_W-1:0]          base_addr = '0;
    logic [7:0]                 tile_count = '0;
    logic                       wt_valid = 1'b0;
    logic signed [DATA_W-1:0]   wt_data = '0;
    logic                       ddr_rdy = 1'b0;
    logic                       ddr_valid = 1'b0;
    logic [ROW_W-1:0]           ddr_data = '0;
    logic                       ddr_en;
    logic [ADDR_W-1:0]          ddr_addr;
    logic                       out_valid;
    logic [ACC_W-1:0]           out_data;
    logic [1:0]                 out_x;
    logic [1:0]                 out_y;
    logic                       out_last;
    logic [1:0]                 reg_full;

    // parsed case file
    string                  case_name[$];
    int                     case_tiles[$];
    int                     case_rdy[$];
    int                     case_wt[$];
    int                     case_pix[$];

    logic [ROW_W-1:0]       ddr_mem [256];
    logic [ADDR_W-1:0]      pend_addr[$];
    int                     pend_due[$];
    logic [ACC_W-1:0]       exp_pix[$];
    logic [1:0]             exp_x[$];
    logic [1:0]             exp_y[$];
    bit                     exp_last[$];
    logic [ADDR_W-1:0]      exp_addr = '0;
    int                     cmds_left = 0;
    string                  cur_name = "reset";
    int                     rdy_pct = 100;
    int                     last_due = 0;
    int                     cyc = 0;
    int                     limit = 0;
    int                     errors = 0;
    int                     checked = 0;

    cnn_tile_top dut0
    (
        .clk_i               ( clk        ),
        .rstn_i              ( rstn       ),
        .start_i             ( start      ),
        .base_addr_i         ( base_addr  ),
        .tile_count_i        ( tile_count ),
        .wt_valid_i          ( wt_valid   ),
        .wt_data_i           ( wt_data    ),
        .ddr_rdy_i           ( ddr_rdy    ),
        .ddr_rd_data_valid_i ( ddr_valid  ),
        .ddr_rd_data_i       ( ddr_data   ),
        .ddr_en_o            ( ddr_en     ),
        .ddr_addr_o          ( ddr_addr   ),
        .out_valid_o         ( out_valid  ),
        .out_data_o          ( out_data   ),
        .out_x_o             ( out_x      ),
        .out_y_o             ( out_y      ),
        .out_last_o          ( out_last   ),
        .reg_matrix_full_o   ( reg_full   )
    );

    always #4 clk = ~clk;

    task automatic check_pixel(input logic [ACC_W-1:0] exp_v, input logic [ACC_W-1:0] act_v);
        checked++;
        if (act_v !== exp_v)
        begin
            $display("Mismatch %s pixel: expected %0d, actual %0d", cur_name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_pos(input string axis, input logic [1:0] exp_v, input logic [1:0] act_v);
        if (act_v !== exp_v)
        begin
            $display("Mismatch %s %s position: expected %0d, actual %0d",
                     cur_name, axis, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_flags(input logic [1:0] exp_v, input logic [1:0] act_v);
        if (act_v !== exp_v)
        begin
            $display("Mismatch %s full flags: expected %b, actual %b", cur_name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_last(input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
        begin
            $display("Mismatch %s last flag: expected %b, actual %b", cur_name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] exp_v, input logic [ADDR_W-1:0] act_v);
        if (act_v !== exp_v)
        begin
            $display("Mismatch %s DDR address: expected %h, actual %h", cur_name, exp_v, act_v);
            errors++;
        end
    endtask

    // header line, then a weight line, then six element rows per tile
    task automatic read_cases();
        int     fd;
        int     n;
        int     want;
        int     step;
        int     rows_left;
        int     v[9];
        string  line;
        string  nm;
        step = 0;
        rows_left = 0;
        fd = $fopen("tests/tile_cases.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the case file tests/tile_cases.txt");
            errors++;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if (line.len() < 2 || line[0] == "#")
                    continue;
                if (step == 0)
                begin
                    want = 3;
                    n = $sscanf(line, "%s %d %d", nm, v[0], v[1]);
                    case_name.push_back(nm);
                    case_tiles.push_back(v[0]);
                    case_rdy.push_back(v[1]);
                    rows_left = v[0] * T_EDGE;
                    step = 1;
                end
                else if (step == 1)
                begin
                    want = 9;
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                    for (int k = 0; k < 9; k++)
                        case_wt.push_back(v[k]);
                    step = (rows_left > 0) ? 2 : 0;
                end
                else
                begin
                    want = T_EDGE;
                    n = $sscanf(line, "%d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5]);
                    for (int k = 0; k < T_EDGE; k++)
                        case_pix.push_back(v[k]);
                    rows_left--;
                    step = (rows_left > 0) ? 2 : 0;
                end
                if (n != want)
                begin
                    $display("case file line has %0d values where %0d were expected", n, want);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic load_ddr(input int base, input int pbase, input int ntiles);
        logic [ROW_W-1:0] beat;
        for (int r = 0; r < ntiles * T_EDGE; r++)
        begin
            for (int e = 0; e < T_EDGE; e++)
                beat[e*DATA_W +: DATA_W] = DATA_W'(case_pix[pbase + r*T_EDGE + e]);
            ddr_mem[8'(base + r)] = beat;
        end
    endtask

    // reference convolution with ReLU in raster order per tile
    task automatic queue_expected(input int wbase, input int pbase, input int ntiles);
        longint sum;
        int     tbase;
        for (int t = 0; t < ntiles; t++)
        begin
            tbase = pbase + t * T_EDGE * T_EDGE;
            for (int y = 0; y < O_EDGE; y++)
            begin
                for (int x = 0; x < O_EDGE; x++)
                begin
                    sum = 0;
                    for (int i = 0; i < K_EDGE; i++)
                        for (int j = 0; j < K_EDGE; j++)
                            sum += longint'(case_wt[wbase + i*K_EDGE + j]) *
                                   case_pix[tbase + (y + i)*T_EDGE + x + j];
                    exp_pix.push_back((sum < 0) ? {ACC_W{1'b0}} : ACC_W'(sum));
                    exp_x.push_back(2'(x));
                    exp_y.push_back(2'(y));
                    exp_last.push_back(x == O_EDGE - 1 && y == O_EDGE - 1);
                end
            end
        end
    endtask

    // DDR model drives ready and returns on the falling edge
    always @(negedge clk)
    begin
        int                 delay;
        logic [ADDR_W-1:0]  a;
        ddr_valid = 1'b0;
        if (!rstn)
            ddr_rdy = 1'b0;
        else
        begin
            ddr_rdy = (int'($urandom % 100) < rdy_pct);
            if (ddr_rdy && ddr_en)
            begin
                if (cmds_left == 0)
                begin
                    $display("%s: a DDR read was issued after the last row of the job", cur_name);
                    errors++;
                end
                else
                begin
                    check_addr(exp_addr, ddr_addr);
                    cmds_left--;
                end
                exp_addr = exp_addr + 1'b1;
                delay = 1 + int'($urandom % 6);
                last_due = (cyc + delay > last_due) ? cyc + delay : last_due + 1;
                pend_addr.push_back(ddr_addr);
                pend_due.push_back(last_due);
            end
            if (pend_due.size() > 0 && pend_due[0] <= cyc)
            begin
                void'(pend_due.pop_front());
                a = pend_addr.pop_front();
                ddr_data = ddr_mem[a[7:0]];
                ddr_valid = 1'b1;
            end
        end
    end

    // output monitor
    always @(negedge clk)
    begin
        if (rstn && out_valid)
        begin
            if (exp_pix.size() == 0)
            begin
                $display("%s: an output pixel came when none was expected", cur_name);
                errors++;
            end
            else
            begin
                check_pixel(exp_pix.pop_front(), out_data);
                check_pos("x", exp_x.pop_front(), out_x);
                check_pos("y", exp_y.pop_front(), out_y);
                check_last(exp_last.pop_front(), out_last);
            end
        end
    end

    always @(posedge clk)
    begin
        cyc = cyc + 1;
        if (limit > 0 && cyc >= limit)
        begin
            $display("timeout: the run did not end within %0d cycles", limit);
            $display("%0d errors, %0d pixels checked", errors + 1, checked);
            $display("Test failed");
            $finish;
        end
    end

    initial
    begin
        int wbase;
        int pbase;
        int total;
        void'($urandom(44));
        read_cases();
        total = 0;
        foreach (case_tiles[c])
            total += case_tiles[c];
        limit = 200 * total + 100;
        if (case_name.size() == 0)
        begin
            $display("no test cases were read");
            errors++;
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        repeat (4) @(negedge clk);
        cur_name = "after_reset";
        check_flags(2'b00, reg_full);
        if (out_valid !== 1'b0)
        begin
            $display("output valid is high after reset with no job started");
            errors++;
        end
        wbase = 0;
        pbase = 0;
        foreach (case_name[c])
        begin
            cur_name = case_name[c];
            rdy_pct = case_rdy[c];
            load_ddr(c * BASE_STEP, pbase, case_tiles[c]);
            queue_expected(wbase, pbase, case_tiles[c]);
            for (int k = 0; k < 9; k++)
            begin
                wt_valid = 1'b1;
                wt_data = DATA_W'(case_wt[wbase + k]);
                @(negedge clk);
            end
            wt_valid = 1'b0;
            start = 1'b1;
            base_addr = ADDR_HIGH | ADDR_W'(c * BASE_STEP);
            tile_count = 8'(case_tiles[c]);
            exp_addr = base_addr;
            cmds_left = case_tiles[c] * T_EDGE;
            @(negedge clk);
            start = 1'b0;
            while (exp_pix.size() != 0)
                @(posedge clk);
            // the released bank clears one cycle after the last pixel
            repeat (2) @(negedge clk);
            check_flags(2'b00, reg_full);
            wbase += 9;
            pbase += case_tiles[c] * T_EDGE * T_EDGE;
        end
        repeat (4) @(negedge clk);
        $display("%0d errors, %0d pixels checked", errors, checked);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== tests/conv_sva.sv ====
/* bound into cnn_tile_top and reads the reader FSM state through the instance hierarchy
   TILE follows the value of the top level through the bind */
`timescale 1ns/10ps
module conv_sva
    import cnn_pkg::*;
#(
    parameter int TILE = cnn_pkg::TILE
)
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        ddr_en_i,
    input  logic        ddr_rdy_i,
    input  logic        out_valid_i,
    input  logic        out_last_i,
    input  rd_state_e   rd_state_i
);

    // output pixels per tile
    localparam int TILE_PIX = (TILE - KS + 1) * (TILE - KS + 1);

    int cmd_cnt;

    // commands accepted since the reader entered REQ
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i || rd_state_i != RD_REQ)
            cmd_cnt <= 0;
        else if (ddr_en_i && ddr_rdy_i)
            cmd_cnt <= cmd_cnt + 1;
    end

    a_en_reset: assert property (@(posedge clk_i) !rstn_i |=> !ddr_en_i)
        else $error("ddr_en_o high after a reset cycle");

    a_last_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_last_i |-> out_valid_i && $past(out_valid_i, TILE_PIX - 1))
        else $error("out_last_o not at the end of a full tile of valid pixels");

    a_req_exit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $fell(rd_state_i == RD_REQ) |-> cmd_cnt == TILE)
        else $error("reader left REQ after %0d commands", cmd_cnt);

    a_cmd_limit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (ddr_en_i && ddr_rdy_i) |-> cmd_cnt < TILE)
        else $error("more than TILE commands in one tile");

endmodule

bind cnn_tile_top conv_sva #(
    .TILE ( TILE )
) sva0
(
    .clk_i       ( clk_i            ),
    .rstn_i      ( rstn_i           ),
    .ddr_en_i    ( ddr_en_o         ),
    .ddr_rdy_i   ( ddr_rdy_i        ),
    .out_valid_i ( out_valid_o      ),
    .out_last_i  ( out_last_o       ),
    .rd_state_i  ( reader_U.state_q )
);

// ==== tests/tile_cases.txt ====
# case line: name, tile count, DDR ready percentage
# then nine kernel weights row-major, then six rows of six elements for each tile
single 1 100
1 2 1 0 1 0 -1 0 1
3 1 4 1 5 9
2 6 5 3 5 8
9 7 9 3 2 3
8 4 6 2 6 4
3 3 8 3 2 7
9 5 0 2 8 8
negative 1 75
-1 -2 -1 0 0 0 1 2 1
50 40 30 20 10 0
45 35 25 15 5 -5
10 20 30 40 50 60
60 50 40 30 20 10
5 5 5 5 5 5
-20 -10 0 10 20 30
multi 4 40
2 -1 0 1 300 -2 0 1 -250
12 -7 33 0 5 -18
4 9 -21 16 2 7
-3 11 8 -25 14 6
27 -9 1 3 -12 20
-15 6 19 -4 8 10
2 -30 5 17 -6 13
100 -200 150 -50 75 -125
60 40 -80 90 -10 30
-45 55 -65 85 20 -95
110 -70 35 -15 5 25
-60 80 -100 45 -35 65
15 -25 50 -75 95 -5
32000 -32000 16000 -16000 8000 -8000
-32768 32767 -1 1 0 12345
20000 -20000 30000 -30000 10000 -10000
7 -7 32767 -32768 256 -256
-12345 23456 -3456 4567 -5678 6789
1 2 3 4 5 6
0 0 0 0 0 0
1 1 1 1 1 1
-1 -1 -1 -1 -1 -1
9 8 7 6 5 4
-9 -8 -7 -6 -5 -4
3 0 -3 0 3 0
